// File: Makefile
TOOL     := verilator
TOP      := dacChainTb
RTL_TOP  := dacChain
FILELIST := sources.f
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing --assert
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := No errors
RUNARGS  := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: hdl/dacChain.sv
`timescale 1ns/100ps

module dacChain (
    input  logic clkin,
    input  logic rst,
    input  logic trig,                                  // start a transfer
    input  logic wrEn,                                  // host setpoint write
    input  dacPkg::dacSetpoint_t wrSet,
    input  logic [dacPkg::numChains-1:0] isQuadDac,     // DAC type strap per chain
    output logic sclk,                                  // shared serial clock
    output logic busy,
    output logic [dacPkg::numChains-1:0] csel,          // chip select per chain
    output logic [dacPkg::numChains-1:0] mosi           // serial data per chain
);

    dacPkg::seqCtrl_t ctrl;                             // shared shifter timing
    logic [dacPkg::chanBits-1:0] addr;                  // word index
    logic flush;
    dacPkg::dacCmdWord_t [dacPkg::numChains-1:0] words; // current word of each chain

    dacSequencer seq0 (
        .clkin (clkin),
        .rst   (rst),
        .trig  (trig),
        .ctrl  (ctrl),
        .addr  (addr),
        .flush (flush),
        .busy  (busy),
        .sclk  (sclk)
    );

    dacCommandStore store0 (
        .clkin (clkin),
        .rst   (rst),
        .wrEn  (wrEn),
        .wrSet (wrSet),
        .addr  (addr),
        .flush (flush),
        .words (words)
    );

    for (genvar i = 0; i < dacPkg::numChains; i++) begin : genShifter
        dacShifter shift0 (
            .clkin  (clkin),
            .rst    (rst),
            .ctrl   (ctrl),
            .word   (words[i]),
            .isQuad (isQuadDac[i]),
            .csel   (csel[i]),
            .mosi   (mosi[i])
        );
    end

endmodule

// File: hdl/dacCommandStore.sv
`timescale 1ns/100ps

module dacCommandStore (
    input  logic clkin,
    input  logic rst,
    input  logic wrEn,                                  // host write strobe
    input  dacPkg::dacSetpoint_t wrSet,                 // chain, channel and data
    input  logic [dacPkg::chanBits-1:0] addr,           // word index from the sequencer
    input  logic flush,                                 // entry addr has been sent
    output dacPkg::dacCmdWord_t [dacPkg::numChains-1:0] words // one word per chain
);

    logic [dacPkg::dataBits-1:0] setpt [dacPkg::numChains][dacPkg::numChans];
    logic [dacPkg::numChans-1:0] pending [dacPkg::numChains]; // new setpoint not sent yet
    logic [dacPkg::numChans-1:0] wrHit [dacPkg::numChains];   // one-hot write per chain
    logic [dacPkg::numChans-1:0] flushHit;                    // one-hot flush, all chains

    // setpoint registers
    always_ff @(posedge clkin) begin
        if (wrEn) begin
            setpt[wrSet.chain][wrSet.chan] <= wrSet.data;
        end
    end

    always_comb begin
        flushHit = '0;
        flushHit[addr] = flush;
    end

    always_comb begin
        for (int c = 0; c < dacPkg::numChains; c++) begin
            wrHit[c] = '0;
            if (wrEn && (int'(wrSet.chain) == c)) begin
                wrHit[c][wrSet.chan] = 1'b1;
            end
        end
    end

    // pending flags, a write in the flush cycle keeps the entry pending
    always_ff @(posedge clkin) begin
        if (rst) begin
            for (int c = 0; c < dacPkg::numChains; c++) begin
                pending[c] <= '0;
            end
        end else begin
            for (int c = 0; c < dacPkg::numChains; c++) begin
                pending[c] <= (pending[c] & ~flushHit) | wrHit[c];
            end
        end
    end

    // command word for the addressed entry of every chain
    always_comb begin
        for (int c = 0; c < dacPkg::numChains; c++) begin
            words[c].pad = '0;
            words[c].cmd = pending[c][addr] ? dacPkg::cmdWrite : dacPkg::cmdNop;
            words[c].chanAddr = 4'(addr);               // quad DAC channel select
            words[c].data = setpt[c][addr];             // stale data goes out with a no-op
        end
    end

endmodule

// File: hdl/dacPkg.sv
package dacPkg;

    // sizing
    localparam int numChains = 2;           // serial chains, one csel/mosi pair each
    localparam int numChans = 4;            // command words per chain per transfer
    localparam int chainBits = 1;           // chain index width in a host write
    localparam int chanBits = 2;            // channel index width, also the word address
    localparam int dataBits = 16;           // setpoint width
    localparam int wordBits = 32;           // serial command word length
    localparam int seqBits = 9;             // sequence counter width

    // DAC command nibbles
    localparam logic [3:0] cmdWrite = 4'h3; // write and update
    localparam logic [3:0] cmdNop = 4'h7;   // no-op, DAC keeps its output

    // sequence counter, 256 counts from init up to done
    localparam logic [seqBits-1:0] seqInit = 9'h100;
    localparam logic [seqBits-1:0] seqDone = 9'h1ff;

    // decode points on counter bits [5:1] within a 64-count word
    localparam logic [4:0] seqWordEdge = 5'b11111;   // last sclk period of a word
    localparam logic [4:0] seqQuadAssert = 5'b00111; // quad csel drops after 8 sclks
    localparam logic [4:0] seqFlush = 5'b01111;      // word is in the shifter by now

    typedef struct packed {
        logic [7:0] pad;              // ignored by the DACs, kept zero
        logic [3:0] cmd;              // cmdWrite or cmdNop
        logic [3:0] chanAddr;         // quad DAC channel, single DACs ignore it
        logic [dataBits-1:0] data;    // output code
    } dacCmdWord_t;

    typedef struct packed {
        logic [chainBits-1:0] chain;  // target chain
        logic [chanBits-1:0] chan;    // target channel within the chain
        logic [dataBits-1:0] data;    // new setpoint
    } dacSetpoint_t;

    typedef struct packed {
        logic load;                   // first word load at start of transfer
        logic shiftEn;                // sclk high, shifters move on the falling edge
        logic reload;                 // word boundary, take the next word
        logic cselN;                  // frame for daisy-chained single DACs
        logic cselQuadN;              // frame for the quad DAC, 24-bit sub-frames
    } seqCtrl_t;

endpackage

// File: hdl/dacSequencer.sv
`timescale 1ns/100ps

module dacSequencer (
    input  logic clkin,
    input  logic rst,
    input  logic trig,                              // start request of one cycle or more
    output dacPkg::seqCtrl_t ctrl,                  // to every shifter
    output logic [dacPkg::chanBits-1:0] addr,       // word index for the command store
    output logic flush,                             // clears the pending flags of addr
    output logic busy,                              // transfer in progress
    output logic sclk                               // serial clock taken from the counter lsb
);

    typedef enum logic {
        stIdle,
        stLoop
    } seqState_t;

    seqState_t state;
    logic [dacPkg::seqBits-1:0] seqn;               // 9-bit sequence counter
    logic cselN;                                    // single DAC frame
    logic cselQuadN;                                // quad DAC frame
    logic again;                                    // trig seen at the last count
    logic start;
    logic wordEdge;
    logic quadAssert;

    assign sclk = seqn[0];                          // toggles every cycle while counting
    assign busy = (state == stLoop);
    assign start = (state == stIdle) && (trig || again); // trig while busy is dropped

    assign wordEdge = (seqn[5:1] == dacPkg::seqWordEdge);
    assign quadAssert = (seqn[5:1] == dacPkg::seqQuadAssert);

    // next word is already addressed when the shifter reloads at the boundary
    assign addr = seqn[7:6] + {1'b0, wordEdge};
    assign flush = busy && sclk && (seqn[5:1] == dacPkg::seqFlush); // one cycle per word

    assign ctrl = '{
        load:      start,
        shiftEn:   busy && sclk,                    // data moves on the sclk fall
        reload:    wordEdge,
        cselN:     cselN,
        cselQuadN: cselQuadN
    };

    always_ff @(posedge clkin) begin
        if (rst) begin
            state <= stIdle;
            seqn <= dacPkg::seqInit;
            cselN <= 1'b1;
            cselQuadN <= 1'b1;
            again <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    seqn <= dacPkg::seqInit;        // park the counter
                    again <= 1'b0;
                    if (start) begin
                        cselN <= 1'b0;              // frame opens with busy
                        state <= stLoop;
                    end else begin
                        cselN <= 1'b1;
                        cselQuadN <= 1'b1;
                    end
                end
                stLoop: begin
                    seqn <= seqn + 9'd1;
                    if (sclk && wordEdge) begin
                        cselQuadN <= 1'b1;          // rising csel latches the quad word
                    end
                    if (sclk && quadAssert) begin
                        cselQuadN <= 1'b0;          // open the 24-bit quad frame
                    end
                    if (seqn == dacPkg::seqDone) begin
                        seqn <= dacPkg::seqInit;
                        cselN <= ~trig;             // held low for a back-to-back start
                        again <= trig;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: hdl/dacShifter.sv
`timescale 1ns/100ps

module dacShifter (
    input  logic clkin,
    input  logic rst,
    input  dacPkg::seqCtrl_t ctrl,              // timing from the sequencer
    input  dacPkg::dacCmdWord_t word,           // this chain's addressed command word
    input  logic isQuad,                        // strap, 1 = quad DAC, 0 = four singles
    output logic csel,                          // chip select for this chain
    output logic mosi                           // serial data, msb first
);

    logic [dacPkg::wordBits-1:0] shiftReg;      // outgoing command word

    assign mosi = shiftReg[dacPkg::wordBits-1];

    // quad DAC needs a csel pulse per word, singles keep one frame
    assign csel = isQuad ? ctrl.cselQuadN : ctrl.cselN;

    always_ff @(posedge clkin) begin
        if (rst) begin
            shiftReg <= '0;                     // mosi idles low
        end else if (ctrl.load) begin
            shiftReg <= word;                   // word 0 before the first sclk rise
        end else if (ctrl.shiftEn) begin
            if (ctrl.reload) begin
                shiftReg <= word;               // next word at the boundary
            end else begin
                shiftReg <= shiftReg << 1;      // next bit on the sclk fall
            end
        end
    end

endmodule

// File: sources.f
hdl/dacPkg.sv
hdl/dacSequencer.sv
hdl/dacCommandStore.sv
hdl/dacShifter.sv
hdl/dacChain.sv
tb/dacChain_assertions.sv
tb/dacChainTb.sv

// File: tb/dacChainTb.sv
`timescale 1ns/100ps

module dacChainTb;

    logic clkin = 1'b0;
    logic rst;
    logic trig;
    logic wrEn;
    dacPkg::dacSetpoint_t wrSet;
    logic [dacPkg::numChains-1:0] isQuadDac;
    logic sclk;
    logic busy;
    logic [dacPkg::numChains-1:0] csel;
    logic [dacPkg::numChains-1:0] mosi;

    // reference model of the host side
    logic [dacPkg::dataBits-1:0] modelSet [dacPkg::numChains][dacPkg::numChans];
    logic modelPend [dacPkg::numChains][dacPkg::numChans];   // written but not yet sent
    dacPkg::dacCmdWord_t expWord [dacPkg::numChains][dacPkg::numChans];
    logic busyQ;

    // serial decoder state
    logic [dacPkg::wordBits-1:0] rxWord [dacPkg::numChains];
    logic [dacPkg::wordBits-1:0] gotWord [dacPkg::numChains];
    logic [4:0] bitCnt;                         // bit within the word
    logic [1:0] wordIdx;                        // word within the transfer
    logic [1:0] gotIdx;                         // index of gotWord
    logic wordValid;                            // one cycle after the 32nd bit

    string testName = "none";
    int errorCount = 0;
    int errAtStart;
    int testCount = 0;
    int failedTests = 0;

    always #2 clkin = ~clkin;                   // 4 ns period

    dacChain dut0 (
        .clkin     (clkin),
        .rst       (rst),
        .trig      (trig),
        .wrEn      (wrEn),
        .wrSet     (wrSet),
        .isQuadDac (isQuadDac),
        .sclk      (sclk),
        .busy      (busy),
        .csel      (csel),
        .mosi      (mosi)
    );

    bind dacChain dacChain_assertions chk0 (
        .clkin     (clkin),
        .rst       (rst),
        .busy      (busy),
        .sclk      (sclk),
        .isQuadDac (isQuadDac),
        .csel      (csel),
        .mosi      (mosi)
    );

    // expected words are fixed when busy rises and the entries then count as flushed
    always @(posedge clkin) begin
        busyQ <= busy;
        if (!rst && busy && !busyQ) begin
            for (int c = 0; c < dacPkg::numChains; c++) begin
                for (int w = 0; w < dacPkg::numChans; w++) begin
                    expWord[c][w].pad = 8'h00;
                    expWord[c][w].cmd = modelPend[c][w] ? dacPkg::cmdWrite : dacPkg::cmdNop;
                    expWord[c][w].chanAddr = 4'(w);
                    expWord[c][w].data = modelSet[c][w];
                    modelPend[c][w] = 1'b0;
                end
            end
        end
    end

    // mosi sampled in the sclk-high cycle with the msb first
    always @(posedge clkin) begin
        wordValid <= 1'b0;
        if (rst || !busy) begin
            bitCnt <= '0;
            wordIdx <= '0;
        end else if (sclk) begin
            for (int c = 0; c < dacPkg::numChains; c++) begin
                rxWord[c] <= {rxWord[c][dacPkg::wordBits-2:0], mosi[c]};
                if (bitCnt == 5'd31) begin
                    gotWord[c] <= {rxWord[c][dacPkg::wordBits-2:0], mosi[c]};
                end
            end
            bitCnt <= bitCnt + 5'd1;
            if (bitCnt == 5'd31) begin
                wordValid <= 1'b1;
                gotIdx <= wordIdx;
                wordIdx <= wordIdx + 2'd1;
            end
        end
    end

    for (genvar c = 0; c < dacPkg::numChains; c++) begin : genWordCheck
        wordMatch: assert property (@(posedge clkin) disable iff (rst)
            wordValid |-> gotWord[c] == expWord[c][gotIdx])
            else begin
                errorCount++;
                $display("ERROR %s: chain %0d word %0d expected %h actual %h",
                    testName, c, gotIdx, expWord[c][gotIdx], gotWord[c]);
            end
    end

    afterReset: assert property (@(posedge clkin) disable iff (rst)
        $fell(rst) |-> (!busy && !sclk && &csel && mosi == '0))
        else begin
            errorCount++;
            $display("%s: outputs not at their reset values", testName);
        end
    idleOutputs: assert property (@(posedge clkin) disable iff (rst)
        (!busy && !$past(busy)) |-> (&csel && mosi == '0 && !sclk))
        else begin
            errorCount++;
            $display("%s: outputs left their idle values", testName);
        end
    startOnTrig: assert property (@(posedge clkin) disable iff (rst)
        $rose(busy) |-> ($past(trig) || $past(trig, 2)))
        else begin
            errorCount++;
            $display("%s: busy rose without a trig", testName);
        end
    normalEnd: assert property (@(posedge clkin) disable iff (rst)
        (!busy && $past(busy) && !$past(trig)) |-> &csel)
        else begin
            errorCount++;
            $display("%s: csel not released at the end", testName);
        end
    backToBackFrame: assert property (@(posedge clkin) disable iff (rst)
        (!busy && $past(busy) && $past(trig)) |-> (csel & ~isQuadDac) == '0)
        else begin
            errorCount++;
            $display("%s: single csel gap between transfers", testName);
        end
    backToBackRestart: assert property (@(posedge clkin) disable iff (rst)
        ($past(busy, 2) && !$past(busy) && $past(trig, 2)) |-> busy)
        else begin
            errorCount++;
            $display("%s: no back-to-back restart", testName);
        end

    function automatic int totalErrors();
        return errorCount + dut0.chk0.failCount;  // tb checks plus bound checks
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $finish;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge clkin);
            #1;
        end
    endtask

    task automatic waitBusy(input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (busy !== level && cnt < limit) begin
            @(posedge clkin);
            #1;
            cnt++;
        end
        if (busy !== level) begin
            abortRun($sformatf("timeout: busy did not go to %0d within %0d cycles",
                level, limit));
        end
    endtask

    task automatic writeSetpoint(input int chain, input int chan, input logic [15:0] data);
        @(posedge clkin);
        #1;
        wrEn = 1'b1;
        wrSet.chain = 1'(chain);
        wrSet.chan = 2'(chan);
        wrSet.data = data;
        modelSet[chain][chan] = data;           // model follows the host write
        modelPend[chain][chan] = 1'b1;
        @(posedge clkin);
        #1;
        wrEn = 1'b0;
    endtask

    task automatic pulseTrig();
        @(posedge clkin);
        #1;
        trig = 1'b1;
        @(posedge clkin);
        #1;
        trig = 1'b0;
    endtask

    task automatic runTransfer();
        pulseTrig();
        waitBusy(1'b1, 8);
        waitBusy(1'b0, 300);
        waitCycles(4);                          // let the last word check fire
    endtask

    task automatic startTest(input string name);
        testName = name;
        errAtStart = totalErrors();
    endtask

    task automatic finishTest();
        int errs;
        errs = totalErrors() - errAtStart;
        testCount++;
        if (errs == 0) begin
            $display("test %s: passed", testName);
        end else begin
            failedTests++;
            $display("test %s: FAILED with %0d errors", testName, errs);
        end
    endtask

    initial begin
        void'($urandom(32'h173d));
        rst = 1'b1;
        trig = 1'b0;
        wrEn = 1'b0;
        wrSet = '0;
        isQuadDac = 2'b10;                      // chain 0 singles and chain 1 quad
        for (int c = 0; c < dacPkg::numChains; c++) begin
            for (int w = 0; w < dacPkg::numChans; w++) begin
                modelPend[c][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clkin);
        #1;
        rst = 1'b0;

        startTest("resetValues");
        waitCycles(20);                         // idle without a trig
        finishTest();

        startTest("writtenSetpoints");
        for (int c = 0; c < dacPkg::numChains; c++) begin
            for (int w = 0; w < dacPkg::numChans; w++) begin
                writeSetpoint(c, w, 16'($urandom));
            end
        end
        runTransfer();
        finishTest();

        startTest("nopAfterFlush");
        runTransfer();                          // nothing new so all no-ops
        writeSetpoint(0, 2, 16'($urandom));
        runTransfer();
        finishTest();

        startTest("quadFraming");
        writeSetpoint(1, 1, 16'($urandom));
        writeSetpoint(1, 3, 16'($urandom));
        runTransfer();
        finishTest();

        startTest("trigDuringBusy");
        writeSetpoint(0, 0, 16'($urandom));
        writeSetpoint(1, 2, 16'($urandom));
        pulseTrig();
        waitBusy(1'b1, 8);
        waitCycles(100);
        pulseTrig();                            // ignored mid-transfer
        waitBusy(1'b0, 300);
        waitCycles(4);
        writeSetpoint(1, 0, 16'($urandom));
        pulseTrig();
        waitBusy(1'b1, 8);
        waitCycles(240);
        trig = 1'b1;                            // held over the last count
        waitBusy(1'b0, 40);
        trig = 1'b0;
        waitBusy(1'b1, 8);                      // restart from the held trig
        waitBusy(1'b0, 300);
        waitCycles(4);
        finishTest();

        startTest("writeDuringTransfer");
        pulseTrig();
        waitBusy(1'b1, 8);
        waitCycles(40);                         // past the flush of entry 0
        writeSetpoint(0, 0, 16'($urandom));
        writeSetpoint(1, 0, 16'($urandom));
        waitBusy(1'b0, 300);
        waitCycles(4);
        runTransfer();                          // entry 0 goes out now
        finishTest();

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, totalErrors());
        if (totalErrors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb/dacChain_assertions.sv
`timescale 1ns/100ps

module dacChain_assertions (
    input logic clkin,
    input logic rst,
    input logic busy,
    input logic sclk,
    input logic [dacPkg::numChains-1:0] isQuadDac,
    input logic [dacPkg::numChains-1:0] csel,
    input logic [dacPkg::numChains-1:0] mosi
);

    logic [8:0] busyLen;                        // cycles since busy rose
    logic quadHigh;                             // quad csel should be high now
    int failCount = 0;                          // read by the testbench at the end

    always_ff @(posedge clkin) begin
        if (rst || !busy) begin
            busyLen <= '0;
        end else begin
            busyLen <= busyLen + 9'd1;
        end
    end

    // first 16 cycles of every 64-cycle word, and always while idle
    assign quadHigh = !busy || (busyLen[5:4] == 2'b00);

    busyLength: assert property (@(posedge clkin) disable iff (rst)
        $fell(busy) |-> busyLen == 9'd256)
        else begin failCount++; $error("busy fell before 256 cycles"); end
    busyBound: assert property (@(posedge clkin) disable iff (rst)
        busy |-> busyLen < 9'd256)
        else begin failCount++; $error("busy stayed high past 256 cycles"); end
    sclkIdle: assert property (@(posedge clkin) disable iff (rst)
        !busy |-> !sclk)
        else begin failCount++; $error("sclk moved while idle"); end
    singleFrame: assert property (@(posedge clkin) disable iff (rst)
        busy |-> (csel & ~isQuadDac) == '0)
        else begin failCount++; $error("single DAC csel went high during busy"); end
    quadFrame: assert property (@(posedge clkin) disable iff (rst)
        ((csel ^ {dacPkg::numChains{quadHigh}}) & isQuadDac) == '0)
        else begin failCount++; $error("quad DAC csel pattern is wrong"); end
    mosiSteady: assert property (@(posedge clkin) disable iff (rst)
        $rose(sclk) |-> $stable(mosi))
        else begin failCount++; $error("mosi changed on a rising sclk"); end

endmodule
